// ==== filelist.f ====
+incdir+include
hdl/cuPkg.sv
hdl/cuConfigRegs.sv
hdl/stageSequencer.sv
hdl/instrDecoder.sv
hdl/ctrlWordGen.sv
hdl/controlUnitTop.sv
tb/tbControlUnit.sv

// ==== hdl/controlUnitTop.sv ====
`timescale 1ns/1ps
`include "cu_defines.svh"

module controlUnitTop (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    wbCyc,
    input  logic                    wbStb,
    input  logic                    wbWe,
    input  logic [`CU_WB_ADR_W-1:0] wbAdr,
    input  logic [`CU_DATA_W-1:0]   wbDatW,
    output logic [`CU_DATA_W-1:0]   wbDatR,
    output logic                    wbAck,
    input  logic [`CU_OPCODE_W-1:0] opcode,  // from external ir
    input  logic [`CU_FUNC_W-1:0]   func,
    output cuPkg::ctrlWord_t        ctrl
);
    import cuPkg::*;

    cfg_t       cfg;
    instClass_t instClass;
    aluFunc_t   aluFunc;
    stage_t     stage;
    logic       lastCycle;

    cuConfigRegs uCfg (
        .clk(clk), .rstN(rstN),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
        .cfg(cfg)
    );

    stageSequencer uSeq (
        .clk(clk), .rstN(rstN), .cfg(cfg), .instClass(instClass),
        .stage(stage), .lastCycle(lastCycle)
    );

    instrDecoder uDec (
        .opcode(opcode), .func(func), .instClass(instClass), .aluFunc(aluFunc)
    );

    ctrlWordGen uGen (
        .stage(stage), .lastCycle(lastCycle), .instClass(instClass),
        .aluFunc(aluFunc), .ctrl(ctrl)
    );

endmodule

// ==== hdl/ctrlWordGen.sv ====
`timescale 1ns/1ps

module ctrlWordGen (
    input  cuPkg::stage_t     stage,
    input  logic              lastCycle,
    input  cuPkg::instClass_t instClass,
    input  cuPkg::aluFunc_t   aluFunc,
    output cuPkg::ctrlWord_t  ctrl
);
    import cuPkg::*;

    logic  isShift;
    srcB_t exSrcB;

    assign isShift = (aluFunc == ALU_SHL) || (aluFunc == ALU_SHR);

    // operand b during execute
    always_comb
    begin
        case (instClass)
            CLS_RTYPE:                                exSrcB = isShift ? SRCB_ONE : SRCB_REG;
            CLS_IMM, CLS_LOAD, CLS_STORE, CLS_BRANCH: exSrcB = SRCB_IMM;
            default:                                  exSrcB = SRCB_REG;
        endcase
    end

    always_comb
    begin
        ctrl = '0; // idle and id drive nothing
        case (stage)
            ST_IF:
            begin
                ctrl.memRead = 1'b1;
                ctrl.aluOp   = ALU_ADD;   // pc + 1
                ctrl.aluSrcA = 1'b0;
                ctrl.aluSrcB = SRCB_ONE;
                ctrl.irWrite = lastCycle; // fetch data valid only now
                ctrl.pcWrite = lastCycle;
            end
            ST_EX1, ST_EX2:
            begin
                ctrl.aluOp       = aluFunc;
                ctrl.aluSrcA     = !isShift;
                ctrl.aluSrcB     = exSrcB;
                ctrl.pcWriteCond = (stage == ST_EX2) && (instClass == CLS_BRANCH);
            end
            ST_MEM:
            begin
                ctrl.iorD     = 1'b1;
                ctrl.memRead  = (instClass == CLS_LOAD);
                ctrl.memWrite = (instClass == CLS_STORE);
            end
            ST_WB:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = (instClass == CLS_LOAD);
                ctrl.regDst   = (instClass == CLS_RTYPE);
            end
            default: ctrl = '0;
        endcase
    end

    // stage and class come from different blocks, so check the combination
    always_comb
    begin
        assert (!(ctrl.memRead && ctrl.memWrite));
        assert (!ctrl.regWrite || stage == ST_WB);
    end

endmodule

// ==== hdl/cuConfigRegs.sv ====
`timescale 1ns/1ps
`include "cu_defines.svh"

module cuConfigRegs (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    wbCyc,
    input  logic                    wbStb,
    input  logic                    wbWe,
    input  logic [`CU_WB_ADR_W-1:0] wbAdr,
    input  logic [`CU_DATA_W-1:0]   wbDatW,
    output logic [`CU_DATA_W-1:0]   wbDatR,
    output logic                    wbAck,
    output cuPkg::cfg_t             cfg
);
    import cuPkg::*;

    logic                  wbReq;
    logic [`CU_WAIT_W-1:0] wrWait;

    // new request, not the cycle already being acked
    assign wbReq = wbCyc && wbStb && !wbAck;

    // a zero wait would wrap the counter
    assign wrWait = (wbDatW[`CU_WAIT_W-1:0] == '0) ? `CU_WAIT_W'(1)
                                                     : wbDatW[`CU_WAIT_W-1:0];

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            wbAck <= 1'b0;
        end
        else
        begin
            wbAck <= wbReq; // single cycle ack
        end
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            cfg.run       <= 1'b0;
            cfg.fetchWait <= `CU_WAIT_W'(`CU_FETCH_WAIT_DEF);
            cfg.memWait   <= `CU_WAIT_W'(`CU_MEM_WAIT_DEF);
        end
        else if (wbReq && wbWe)
        begin
            case (wbAdr)
                `CU_WB_ADR_W'(0): cfg.run       <= wbDatW[0];
                `CU_WB_ADR_W'(1): cfg.fetchWait <= wrWait;
                `CU_WB_ADR_W'(2): cfg.memWait   <= wrWait;
                default: ; // address 3 has no register
            endcase
        end
    end

    // read data is held by the master address while ack is high
    always_comb
    begin
        wbDatR = '0;
        case (wbAdr)
            `CU_WB_ADR_W'(0): wbDatR[0] = cfg.run;
            `CU_WB_ADR_W'(1): wbDatR[`CU_WAIT_W-1:0] = cfg.fetchWait;
            `CU_WB_ADR_W'(2): wbDatR[`CU_WAIT_W-1:0] = cfg.memWait;
            default: wbDatR = '0;
        endcase
    end

endmodule

// ==== hdl/cuPkg.sv ====
`include "cu_defines.svh"

package cuPkg;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_IF,
        ST_ID,
        ST_EX1,
        ST_EX2,
        ST_MEM,
        ST_WB
    } stage_t;

    // isa opcode values
    typedef enum logic [`CU_OPCODE_W-1:0] {
        OP_BNE = 0,
        OP_BEQ = 1,
        OP_BGZ = 2,
        OP_BLZ = 3,
        OP_ADI = 4,
        OP_ORI = 5,
        OP_LWD = 7,
        OP_SWD = 8,
        OP_ALU = 15
    } opcode_t;

    // r-type function codes
    typedef enum logic [`CU_FUNC_W-1:0] {
        FN_ADD = 0,
        FN_SUB = 1,
        FN_AND = 2,
        FN_ORR = 3,
        FN_NOT = 4,
        FN_TCP = 5,
        FN_SHL = 6,
        FN_SHR = 7
    } func_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_ORR,
        ALU_NOT,
        ALU_TCP,
        ALU_SHL,
        ALU_SHR,
        ALU_BNE,
        ALU_BEQ,
        ALU_BGZ,
        ALU_BLZ
    } aluFunc_t;

    typedef enum logic [2:0] {
        CLS_RTYPE,
        CLS_IMM,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_ILLEGAL
    } instClass_t;

    typedef enum logic [1:0] {
        SRCB_REG,
        SRCB_ONE,
        SRCB_IMM
    } srcB_t;

    typedef struct packed {
        logic     pcWrite;
        logic     pcWriteCond;
        logic     iorD;         // 1 selects the data address
        logic     memRead;
        logic     memWrite;
        logic     memToReg;
        logic     irWrite;
        logic     aluSrcA;      // 0 pc, 1 register
        srcB_t    aluSrcB;
        aluFunc_t aluOp;
        logic     regWrite;
        logic     regDst;       // 1 rd, 0 rt
    } ctrlWord_t;

    typedef struct packed {
        logic                  run;
        logic [`CU_WAIT_W-1:0] fetchWait;
        logic [`CU_WAIT_W-1:0] memWait;
    } cfg_t;

endpackage

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/1ps
`include "cu_defines.svh"

module instrDecoder (
    input  logic [`CU_OPCODE_W-1:0] opcode,
    input  logic [`CU_FUNC_W-1:0]   func,
    output cuPkg::instClass_t       instClass,
    output cuPkg::aluFunc_t         aluFunc
);
    import cuPkg::*;

    instClass_t rClass;
    aluFunc_t   rFunc;

    // r-type function table
    always_comb
    begin
        rClass = CLS_RTYPE;
        case (func)
            FN_ADD:  rFunc = ALU_ADD;
            FN_SUB:  rFunc = ALU_SUB;
            FN_AND:  rFunc = ALU_AND;
            FN_ORR:  rFunc = ALU_ORR;
            FN_NOT:  rFunc = ALU_NOT;
            FN_TCP:  rFunc = ALU_TCP;
            FN_SHL:  rFunc = ALU_SHL;
            FN_SHR:  rFunc = ALU_SHR;
            default:
            begin
                rClass = CLS_ILLEGAL; // jumps, wwd, hlt land here too
                rFunc  = ALU_ADD;
            end
        endcase
    end

    always_comb
    begin
        instClass = CLS_ILLEGAL;
        aluFunc   = ALU_ADD;
        case (opcode)
            OP_ALU:
            begin
                instClass = rClass;
                aluFunc   = rFunc;
            end
            OP_ADI: instClass = CLS_IMM;
            OP_ORI:
            begin
                instClass = CLS_IMM;
                aluFunc   = ALU_ORR;
            end
            OP_LWD: instClass = CLS_LOAD;   // address is reg + imm
            OP_SWD: instClass = CLS_STORE;
            OP_BNE:
            begin
                instClass = CLS_BRANCH;
                aluFunc   = ALU_BNE;
            end
            OP_BEQ:
            begin
                instClass = CLS_BRANCH;
                aluFunc   = ALU_BEQ;
            end
            OP_BGZ:
            begin
                instClass = CLS_BRANCH;
                aluFunc   = ALU_BGZ;
            end
            OP_BLZ:
            begin
                instClass = CLS_BRANCH;
                aluFunc   = ALU_BLZ;
            end
            default: instClass = CLS_ILLEGAL;
        endcase
    end

endmodule

// ==== hdl/stageSequencer.sv ====
`timescale 1ns/1ps
`include "cu_defines.svh"

module stageSequencer (
    input  logic              clk,
    input  logic              rstN,
    input  cuPkg::cfg_t       cfg,
    input  cuPkg::instClass_t instClass,
    output cuPkg::stage_t     stage,
    output logic              lastCycle
);
    import cuPkg::*;

    stage_t                stageNext;
    logic [`CU_WAIT_W-1:0] waitCnt;
    logic [`CU_WAIT_W-1:0] waitNext;
    logic                  waitDone;
    stage_t                doneStage;   // where a finished instruction goes
    logic [`CU_WAIT_W-1:0] doneWait;

    assign waitDone  = (waitCnt == '0);
    assign lastCycle = waitDone && (stage == ST_IF || stage == ST_MEM);

    // stop at an instruction boundary once run is cleared
    assign doneStage = cfg.run ? ST_IF : ST_IDLE;
    assign doneWait  = cfg.run ? cfg.fetchWait - 1'b1 : '0;

    always_comb
    begin
        stageNext = stage;
        waitNext  = waitCnt;
        case (stage)
            ST_IDLE:
            begin
                if (cfg.run)
                begin
                    stageNext = ST_IF;
                    waitNext  = cfg.fetchWait - 1'b1;
                end
            end
            ST_IF:
            begin
                if (waitDone)
                    stageNext = ST_ID;
                else
                    waitNext = waitCnt - 1'b1;
            end
            ST_ID:  stageNext = ST_EX1;
            ST_EX1: stageNext = ST_EX2;
            ST_EX2:
            begin
                case (instClass)
                    CLS_LOAD, CLS_STORE:
                    begin
                        stageNext = ST_MEM;
                        waitNext  = cfg.memWait - 1'b1; // sampled at phase entry
                    end
                    CLS_RTYPE, CLS_IMM: stageNext = ST_WB;
                    default:
                    begin
                        stageNext = doneStage;   // branch or illegal
                        waitNext  = doneWait;
                    end
                endcase
            end
            ST_MEM:
            begin
                if (!waitDone)
                    waitNext = waitCnt - 1'b1;
                else if (instClass == CLS_LOAD)
                    stageNext = ST_WB;
                else
                begin
                    stageNext = doneStage;
                    waitNext  = doneWait;
                end
            end
            ST_WB:
            begin
                stageNext = doneStage;
                waitNext  = doneWait;
            end
            default: stageNext = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            stage   <= ST_IDLE;
            waitCnt <= '0;
        end
        else
        begin
            stage   <= stageNext;
            waitCnt <= waitNext;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        (stage == ST_WB) |-> $past(stage == ST_EX2 || stage == ST_MEM));

    // mem only while the held instruction is a load or store
    assert property (@(posedge clk) disable iff (!rstN)
        (stage == ST_MEM) |-> (instClass inside {CLS_LOAD, CLS_STORE}));

endmodule

// ==== include/cu_defines.svh ====
`ifndef CU_DEFINES_SVH
`define CU_DEFINES_SVH

// wishbone data bus
`define CU_DATA_W 16

// instruction fields
`define CU_OPCODE_W 4
`define CU_FUNC_W 6

// config register select, four words
`define CU_WB_ADR_W 2

// wait counter width
`define CU_WAIT_W 4

// memory latency after reset, in cycles
`define CU_FETCH_WAIT_DEF 4
`define CU_MEM_WAIT_DEF 4

`endif

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tbControlUnit -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output="$(./obj_dir/VtbControlUnit)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

// ==== tb/tbControlUnit.sv ====
`timescale 1ns/1ps
`include "cu_defines.svh"

module tbControlUnit;
    import cuPkg::*;

    logic                    clk = 1'b0;
    logic                    rstN = 1'b0;
    logic                    wbCyc = 1'b0;
    logic                    wbStb = 1'b0;
    logic                    wbWe = 1'b0;
    logic [`CU_WB_ADR_W-1:0] wbAdr = '0;
    logic [`CU_DATA_W-1:0]   wbDatW = '0;
    logic [`CU_DATA_W-1:0]   wbDatR;
    logic                    wbAck;
    logic [`CU_OPCODE_W-1:0] opcode = '0;
    logic [`CU_FUNC_W-1:0]   func = '0;
    ctrlWord_t               ctrl;

    int         errCnt = 0;
    int         passCnt = 0;
    int         failCnt = 0;
    int         errAtStart = 0;
    int         expFetch = `CU_FETCH_WAIT_DEF;
    int         expMem = `CU_MEM_WAIT_DEF;
    int         fetchRun = 0;   // consecutive fetch reads so far
    int         memRun = 0;     // consecutive data-address cycles so far
    int         regWrCnt = 0;
    int         condCnt = 0;
    logic [7:0] lfsr = 8'd90;

    controlUnitTop uut (
        .clk(clk), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
        .opcode(opcode), .func(func), .ctrl(ctrl)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        fetchRun <= (ctrl.memRead && !ctrl.iorD) ? fetchRun + 1 : 0;
        memRun   <= ctrl.iorD ? memRun + 1 : 0;
    end

    always @(negedge clk)
    begin
        if (ctrl.regWrite)
            regWrCnt++;
        if (ctrl.pcWriteCond)
            condCnt++;
    end

    // expected alu function, taken from the isa tables
    function automatic aluFunc_t expAlu(input logic [3:0] op, input logic [5:0] fn);
        aluFunc_t rTable [8];
        rTable = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR, ALU_NOT, ALU_TCP, ALU_SHL, ALU_SHR};
        case (op)
            4'd15:   return rTable[fn[2:0]];
            4'd5:    return ALU_ORR;
            4'd0:    return ALU_BNE;
            4'd1:    return ALU_BEQ;
            4'd2:    return ALU_BGZ;
            4'd3:    return ALU_BLZ;
            default: return ALU_ADD;
        endcase
    endfunction

    function automatic srcB_t expSrcB(input logic [3:0] op, input logic [5:0] fn);
        if (op != 4'd15)
            return SRCB_IMM;
        return (fn == 6'd6 || fn == 6'd7) ? SRCB_ONE : SRCB_REG;
    endfunction

    task automatic reportValue(input string name, input int expV, input int gotV);
        $display("Fail at %0t ns: %s expected %0d got %0d", $time, name, expV, gotV);
        errCnt++;
    endtask

    task automatic abortRun(input string why);
        $display("Timeout at %0t ns: %s", $time, why);
        $display("Test failed");
        $finish;
    endtask

    task automatic getBits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            v = (v << 1) | lfsr[0];
        end
    endtask

    assert property (@(posedge clk) disable iff (!rstN) wbAck |=> !wbAck)
        else reportValue("wbAck", 0, 1);
    assert property (@(posedge clk) disable iff (!rstN) ctrl.irWrite |-> fetchRun == expFetch - 1)
        else reportValue("memRead cycles", expFetch, $sampled(fetchRun) + 1);
    assert property (@(posedge clk) disable iff (!rstN)
        ctrl.pcWrite == (ctrl.memRead && !ctrl.iorD && fetchRun == expFetch - 1))
        else reportValue("pcWrite", !$sampled(ctrl.pcWrite), $sampled(ctrl.pcWrite));
    assert property (@(posedge clk) disable iff (!rstN)
        (ctrl.memRead && !ctrl.iorD)
            |-> {ctrl.aluOp, ctrl.aluSrcB, ctrl.aluSrcA} == {ALU_ADD, SRCB_ONE, 1'b0})
        else reportValue("fetch aluOp/aluSrcB/aluSrcA", {ALU_ADD, SRCB_ONE, 1'b0},
            $sampled({ctrl.aluOp, ctrl.aluSrcB, ctrl.aluSrcA}));
    assert property (@(posedge clk) disable iff (!rstN) $fell(ctrl.iorD) |-> memRun == expMem)
        else reportValue("iorD cycles", expMem, $sampled(memRun));
    assert property (@(posedge clk) disable iff (!rstN)
        ($past(ctrl.irWrite, 2) || $past(ctrl.irWrite, 3)) |-> ctrl.aluOp == expAlu(opcode, func))
        else reportValue("aluOp", expAlu(opcode, func), $sampled(ctrl.aluOp));
    assert property (@(posedge clk) disable iff (!rstN)
        ($past(ctrl.irWrite, 2) || $past(ctrl.irWrite, 3)) |-> ctrl.aluSrcB == expSrcB(opcode, func))
        else reportValue("aluSrcB", expSrcB(opcode, func), $sampled(ctrl.aluSrcB));
    assert property (@(posedge clk) disable iff (!rstN)
        ($past(ctrl.irWrite, 2) || $past(ctrl.irWrite, 3))
            |-> ctrl.aluSrcA == !(opcode == OP_ALU && func inside {6'd6, 6'd7}))
        else reportValue("aluSrcA", !$sampled(ctrl.aluSrcA), $sampled(ctrl.aluSrcA));
    assert property (@(posedge clk) disable iff (!rstN)
        ctrl.regWrite |-> ctrl.memToReg == (opcode == OP_LWD))
        else reportValue("memToReg", opcode == OP_LWD, $sampled(ctrl.memToReg));
    assert property (@(posedge clk) disable iff (!rstN)
        ctrl.regWrite |-> ctrl.regDst == (opcode == OP_ALU))
        else reportValue("regDst", opcode == OP_ALU, $sampled(ctrl.regDst));
    assert property (@(posedge clk) disable iff (!rstN)
        ctrl.memWrite == (ctrl.iorD && opcode == OP_SWD))
        else reportValue("memWrite", !$sampled(ctrl.memWrite), $sampled(ctrl.memWrite));
    assert property (@(posedge clk) disable iff (!rstN) $past(ctrl.pcWriteCond) |-> ctrl.memRead)
        else reportValue("memRead after branch", 1, 0);

    task automatic wbAccess(input logic we, input int adr, input int dat, output int rd);
        int n;
        @(posedge clk);
        wbCyc  <= 1'b1;
        wbStb  <= 1'b1;
        wbWe   <= we;
        wbAdr  <= adr[`CU_WB_ADR_W-1:0];
        wbDatW <= dat[`CU_DATA_W-1:0];
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
            if (n > 10)
                abortRun("no wishbone acknowledge");
        end
        while (!wbAck);
        rd = wbDatR;
        @(posedge clk);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
    endtask

    task automatic checkRead(input int adr, input int expV);
        int rd;
        wbAccess(1'b0, adr, 0, rd);
        assert (rd == expV) else reportValue($sformatf("wbDatR[%0d]", adr), expV, rd);
    endtask

    task automatic waitIrWrite();
        int n;
        n = 0;
        while (!ctrl.irWrite)
        begin
            @(negedge clk);
            n++;
            if (n > 40)
                abortRun("no instruction fetch completed");
        end
    endtask

    // plays the external instruction register for one instruction
    task automatic issueInstr(input logic [3:0] op, input logic [5:0] fn);
        int n;
        int expLen;
        int wr0;
        int cond0;
        waitIrWrite();
        @(posedge clk);
        opcode <= op;
        func   <= fn;
        wr0    = regWrCnt;
        cond0  = condCnt;
        expLen = (op == OP_LWD) ? expMem + 5 : (op == OP_SWD) ? expMem + 4 :
                 (op <= 4'd3) ? 4 : 5;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
            if (n > 40)
                abortRun("instruction never returned to fetch");
        end
        while (!(ctrl.memRead && !ctrl.iorD));
        assert (n == expLen) else reportValue("instruction length", expLen, n);
        assert (regWrCnt - wr0 == ((op <= 4'd3 || op == OP_SWD) ? 0 : 1))
            else reportValue("regWrite pulses", (op <= 4'd3 || op == OP_SWD) ? 0 : 1, regWrCnt - wr0);
        assert (condCnt - cond0 == ((op <= 4'd3) ? 1 : 0))
            else reportValue("pcWriteCond pulses", (op <= 4'd3) ? 1 : 0, condCnt - cond0);
    endtask

    task automatic finishTest(input string name);
        if (errCnt == errAtStart)
        begin
            passCnt++;
            $display("test %s: ok", name);
        end
        else
        begin
            failCnt++;
            $display("test %s: %0d errors", name, errCnt - errAtStart);
        end
        errAtStart = errCnt;
    endtask

    initial
    begin
        int v;
        int rd;
        int wr0;
        logic [3:0] memOps [2];
        memOps = '{OP_LWD, OP_SWD};

        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        assert (ctrl == '0) else reportValue("ctrl", 0, ctrl);
        checkRead(0, 0);
        checkRead(1, 4);
        checkRead(2, 4);
        finishTest("reset");

        wbAccess(1'b1, 1, 0, rd);
        checkRead(1, 1);
        wbAccess(1'b1, 2, 9, rd);
        checkRead(2, 9);
        wbAccess(1'b1, 3, 5, rd);
        checkRead(3, 0);
        finishTest("wishbone");

        getBits(3, v);
        expFetch = (v == 0) ? 1 : v;   // zero is stored as one
        wbAccess(1'b1, 1, v, rd);
        getBits(3, v);
        expMem = (v == 0) ? 1 : v;
        wbAccess(1'b1, 2, v, rd);
        wbAccess(1'b1, 0, 1, rd);
        for (int i = 0; i < 8; i++)
        begin
            getBits(3, v);
            issueInstr(OP_ALU, 6'(v));
        end
        finishTest("rtype");

        for (int i = 0; i < 4; i++)
            issueInstr(memOps[i % 2], 6'd0);
        finishTest("load store");

        getBits(2, v);
        for (int i = 0; i < 4; i++)
            issueInstr(4'((v + i) % 4), 6'd0);
        finishTest("branch");

        waitIrWrite();
        @(posedge clk);
        opcode <= OP_ADI;
        wr0 = regWrCnt;
        wbAccess(1'b1, 0, 0, rd);
        for (int i = 0; i < 30; i++)
        begin
            @(negedge clk);
            if (i > 2)
                assert (!ctrl.memRead) else reportValue("memRead after stop", 0, 1);
        end
        assert (regWrCnt - wr0 == 1) else reportValue("regWrite pulses", 1, regWrCnt - wr0);
        finishTest("run clear");

        $display("tests passed %0d, failed %0d, errors %0d", passCnt, failCnt, errCnt);
        if (errCnt == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule
